// File: sim.f
mipsPkg.sv
fetchStage.sv
regFile.sv
decodeStage.sv
executeStage.sv
memAccess.sv
hazardUnit.sv
datapath.sv
tbDatapath.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tbDatapath -o simv
./obj_dir/simv > sim.log
cat sim.log
if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
else
    exit 1
fi

// File: tbDatapath.sv
module tbDatapath;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int maxRows = 64;

    logic                 clk;
    logic                 arstN_i;
    logic                 iStall_i;
    logic                 dStall_i;
    mipsPkg::wordT        instr_i;
    mipsPkg::wordT        memRdata_i;
    mipsPkg::wordT        instAddr_o;
    logic                 instEn_o;
    logic                 memEn_o;
    mipsPkg::wordT        memAddr_o;
    logic [3:0]           memWen_o;
    mipsPkg::wordT        memWdata_o;
    logic                 longestStall_o;
    mipsPkg::wordT        debugWbPc_o;
    logic [3:0]           debugWbRfWen_o;
    mipsPkg::regAddrT     debugWbRfWnum_o;
    mipsPkg::wordT        debugWbRfWdata_o;

    // program table, one row per instruction address
    mipsPkg::wordT        progInstr [maxRows];
    logic                 expWb     [maxRows];   // row writes a register
    mipsPkg::regAddrT     expReg    [maxRows];
    mipsPkg::wordT        expData   [maxRows];
    int                   rowCount;
    int                   expCount;
    int                   seenCount;
    int                   nextRow;
    int                   mismatches;
    int                   otherErrors;
    int                   liveEdges;     // rising edges since reset release
    logic [31:0]          rnd;

    mipsPkg::wordT        rom [64];
    mipsPkg::wordT        ram [64];
    mipsPkg::wordT        romOff;

    datapath u_dut (
        .clk(clk), .arstN_i(arstN_i), .instr_i(instr_i), .iStall_i(iStall_i),
        .memRdata_i(memRdata_i), .dStall_i(dStall_i),
        .instAddr_o(instAddr_o), .instEn_o(instEn_o),
        .memEn_o(memEn_o), .memAddr_o(memAddr_o), .memWen_o(memWen_o),
        .memWdata_o(memWdata_o), .longestStall_o(longestStall_o),
        .debugWbPc_o(debugWbPc_o), .debugWbRfWen_o(debugWbRfWen_o),
        .debugWbRfWnum_o(debugWbRfWnum_o), .debugWbRfWdata_o(debugWbRfWdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // instruction ROM, zero (nop) outside the program
    assign romOff  = instAddr_o - mipsPkg::pcReset;
    assign instr_i = (romOff[31:8] == 24'd0) ? rom[romOff[7:2]] : '0;

    assign memRdata_i = ram[memAddr_o[7:2]];

    always @(posedge clk) begin
        if (memEn_o && !(iStall_i || dStall_i)) begin
            for (int b = 0; b < 4; b++) begin
                if (memWen_o[b])
                    ram[memAddr_o[7:2]][8*b +: 8] <= memWdata_o[8*b +: 8];
            end
        end
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic mipsPkg::wordT encR(logic [5:0] fn, mipsPkg::regAddrT rs,
                                           mipsPkg::regAddrT rt, mipsPkg::regAddrT rd,
                                           logic [4:0] sa);
        return {mipsPkg::opSpecial, rs, rt, rd, sa, fn};
    endfunction

    function automatic mipsPkg::wordT encI(logic [5:0] op, mipsPkg::regAddrT rs,
                                           mipsPkg::regAddrT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // jump to the table row idx
    function automatic mipsPkg::wordT encJ(logic [5:0] op, int idx);
        mipsPkg::wordT target;
        target = mipsPkg::pcReset + (32'(idx) << 2);
        return {op, target[27:2]};
    endfunction

    task automatic addRow(mipsPkg::wordT instr, logic wb, mipsPkg::regAddrT rd,
                          mipsPkg::wordT data);
        progInstr[rowCount] = instr;
        expWb[rowCount]     = wb;
        expReg[rowCount]    = rd;
        expData[rowCount]   = data;
        rowCount++;
        if (wb)
            expCount++;
    endtask

    task automatic checkWord(string name, mipsPkg::wordT got, mipsPkg::wordT exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkReg(string name, mipsPkg::regAddrT got, mipsPkg::regAddrT exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic buildProgram();
        // alu, constants, forwarding at distance 1 and 2
        addRow(encI(mipsPkg::opLui, 5'd0, 5'd1, 16'h1234), 1'b1, 5'd1, 32'h1234_0000);
        addRow(encI(mipsPkg::opOri, 5'd1, 5'd1, 16'h5678), 1'b1, 5'd1, 32'h1234_5678);
        addRow(encI(mipsPkg::opAddiu, 5'd0, 5'd2, 16'hfffd), 1'b1, 5'd2, 32'hffff_fffd);
        addRow(encR(mipsPkg::fnAddu, 5'd1, 5'd2, 5'd3, 5'd0), 1'b1, 5'd3, 32'h1234_5675);
        addRow(encR(mipsPkg::fnSubu, 5'd2, 5'd1, 5'd4, 5'd0), 1'b1, 5'd4, 32'hedcb_a985);
        addRow(encR(mipsPkg::fnAnd, 5'd1, 5'd2, 5'd5, 5'd0), 1'b1, 5'd5, 32'h1234_5678);
        addRow(encR(mipsPkg::fnOr, 5'd4, 5'd3, 5'd6, 5'd0), 1'b1, 5'd6, 32'hffff_fff5);
        addRow(encR(mipsPkg::fnXor, 5'd1, 5'd3, 5'd7, 5'd0), 1'b1, 5'd7, 32'h0000_000d);
        addRow(encR(mipsPkg::fnSlt, 5'd2, 5'd1, 5'd8, 5'd0), 1'b1, 5'd8, 32'h0000_0001);
        addRow(encR(mipsPkg::fnSlt, 5'd1, 5'd2, 5'd9, 5'd0), 1'b1, 5'd9, 32'h0000_0000);
        addRow(encR(mipsPkg::fnSll, 5'd0, 5'd1, 5'd10, 5'd4), 1'b1, 5'd10, 32'h2345_6780);
        // loads and stores around word 16
        addRow(encI(mipsPkg::opAddiu, 5'd0, 5'd11, 16'h0040), 1'b1, 5'd11, 32'h0000_0040);
        addRow(encI(mipsPkg::opSw, 5'd11, 5'd1, 16'h0000), 1'b0, 5'd0, '0);
        addRow(encI(mipsPkg::opSb, 5'd11, 5'd4, 16'h0001), 1'b0, 5'd0, '0);
        addRow(encI(mipsPkg::opLw, 5'd11, 5'd12, 16'h0000), 1'b1, 5'd12, 32'h1234_8578);
        addRow(encR(mipsPkg::fnAddu, 5'd12, 5'd12, 5'd13, 5'd0), 1'b1, 5'd13, 32'h2469_0af0);
        addRow(encI(mipsPkg::opLb, 5'd11, 5'd14, 16'h0001), 1'b1, 5'd14, 32'hffff_ff85);
        addRow(encI(mipsPkg::opAddiu, 5'd14, 5'd15, 16'h0001), 1'b1, 5'd15, 32'hffff_ff86);
        addRow(encI(mipsPkg::opLb, 5'd11, 5'd16, 16'h0002), 1'b1, 5'd16, 32'h0000_0034);
        // branches with delay slots, rows marked 0 must never retire
        addRow(encI(mipsPkg::opBeq, 5'd1, 5'd1, 16'h0002), 1'b0, 5'd0, '0);
        addRow(encI(mipsPkg::opAddiu, 5'd0, 5'd17, 16'h0011), 1'b1, 5'd17, 32'h0000_0011);
        addRow(encI(mipsPkg::opAddiu, 5'd0, 5'd18, 16'h0bad), 1'b0, 5'd0, '0);
        addRow(encI(mipsPkg::opBne, 5'd1, 5'd1, 16'h0002), 1'b0, 5'd0, '0);
        addRow(encI(mipsPkg::opAddiu, 5'd0, 5'd19, 16'h0022), 1'b1, 5'd19, 32'h0000_0022);
        addRow(encI(mipsPkg::opAddiu, 5'd0, 5'd20, 16'h0033), 1'b1, 5'd20, 32'h0000_0033);
        addRow(encI(mipsPkg::opBne, 5'd2, 5'd1, 16'h0002), 1'b0, 5'd0, '0);
        addRow(encI(mipsPkg::opAddiu, 5'd0, 5'd21, 16'h0044), 1'b1, 5'd21, 32'h0000_0044);
        addRow(encI(mipsPkg::opAddiu, 5'd0, 5'd22, 16'h0bad), 1'b0, 5'd0, '0);
        addRow(encI(mipsPkg::opBeq, 5'd2, 5'd1, 16'h0002), 1'b0, 5'd0, '0);
        addRow(encI(mipsPkg::opAddiu, 5'd0, 5'd23, 16'h0055), 1'b1, 5'd23, 32'h0000_0055);
        // jumps
        addRow(encJ(mipsPkg::opJ, 33), 1'b0, 5'd0, '0);
        addRow(encI(mipsPkg::opAddiu, 5'd0, 5'd24, 16'h0066), 1'b1, 5'd24, 32'h0000_0066);
        addRow(encI(mipsPkg::opAddiu, 5'd0, 5'd25, 16'h0bad), 1'b0, 5'd0, '0);
        addRow(encJ(mipsPkg::opJal, 36), 1'b1, mipsPkg::regRa, 32'hbfc0_008c);
        addRow(encI(mipsPkg::opAddiu, 5'd0, 5'd26, 16'h0077), 1'b1, 5'd26, 32'h0000_0077);
        addRow(encI(mipsPkg::opAddiu, 5'd0, 5'd27, 16'h0bad), 1'b0, 5'd0, '0);
        addRow(encR(mipsPkg::fnAddu, 5'd31, 5'd0, 5'd28, 5'd0), 1'b1, 5'd28, 32'hbfc0_008c);
        addRow(encI(mipsPkg::opAddiu, 5'd28, 5'd29, 16'h0001), 1'b1, 5'd29, 32'hbfc0_008d);
    endtask

    // write-back monitor, sampled mid-cycle
    always @(negedge clk) begin
        checkBit("longestStall_o", longestStall_o, iStall_i | dStall_i);
        checkBit("instEn_o", instEn_o, liveEdges > 0);
        if (!arstN_i)
            checkBit("memEn_o", memEn_o, 1'b0);
        if (debugWbRfWen_o !== 4'h0) begin
            if (!arstN_i || iStall_i || dStall_i) begin
                otherErrors++;
                $display("write strobe seen in reset or while frozen, pc %h", debugWbPc_o);
            end else if (debugWbRfWen_o !== 4'hf) begin
                mismatches++;
                $display("MISMATCH debugWbRfWen_o: got %h, expected %h", debugWbRfWen_o, 4'hf);
            end else begin
                while (nextRow < rowCount && !expWb[nextRow])
                    nextRow++;
                if (nextRow >= rowCount) begin
                    otherErrors++;
                    $display("write-back after the last expected one, pc %h", debugWbPc_o);
                end else begin
                    checkWord("debugWbPc_o", debugWbPc_o,
                              mipsPkg::pcReset + (32'(nextRow) << 2));
                    checkReg("debugWbRfWnum_o", debugWbRfWnum_o, expReg[nextRow]);
                    checkWord("debugWbRfWdata_o", debugWbRfWdata_o, expData[nextRow]);
                    nextRow++;
                    seenCount++;
                end
            end
        end
    end

    // random freezes, about one cycle in four each
    always @(posedge clk) begin
        if (arstN_i) begin
            liveEdges++;
            #1;
            rnd = xorshift(rnd);
            iStall_i <= (rnd[1:0] == 2'b00);
            dStall_i <= (rnd[9:8] == 2'b00);
        end
    end

    initial begin
        arstN_i     = 1'b0;
        iStall_i    = 1'b0;
        dStall_i    = 1'b0;
        rnd         = 32'h1d33;
        rowCount    = 0;
        expCount    = 0;
        seenCount   = 0;
        nextRow     = 0;
        mismatches  = 0;
        otherErrors = 0;
        liveEdges   = 0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = '0;
            ram[i] = 32'hd00d_0000 ^ (32'(i) << 2);
        end
        buildProgram();
        for (int i = 0; i < rowCount; i++)
            rom[i] = progInstr[i];

        fork
            begin
                #((rowCount * 8 + 8) * 20);
                $display("timeout: %0d of %0d write-backs seen", seenCount, expCount);
                $display("TESTS FAILED");
                $finish;
            end
        join_none

        repeat (8) @(posedge clk);
        #1 arstN_i = 1'b1;

        wait (seenCount == expCount);
        repeat (20) @(posedge clk);   // trailing nops must stay silent
        #1;
        checkWord("ram[16]", ram[16], 32'h1234_8578);

        $display("errors: %0d mismatches, %0d other", mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: datapath.sv
module datapath (
    input  logic             clk,
    input  logic             arstN_i,
    input  mipsPkg::wordT    instr_i,
    input  logic             iStall_i,
    input  mipsPkg::wordT    memRdata_i,
    input  logic             dStall_i,
    output mipsPkg::wordT    instAddr_o,
    output logic             instEn_o,
    output logic             memEn_o,
    output mipsPkg::wordT    memAddr_o,
    output logic [3:0]       memWen_o,
    output mipsPkg::wordT    memWdata_o,
    output logic             longestStall_o,
    output mipsPkg::wordT    debugWbPc_o,
    output logic [3:0]       debugWbRfWen_o,
    output mipsPkg::regAddrT debugWbRfWnum_o,
    output mipsPkg::wordT    debugWbRfWdata_o
);

    logic             freeze, loadUseStall, flushD, jumpD, branchTaken, rfWe;
    logic             aluImmE, regWriteE, isBranchE, branchNeE, regWriteM, regWriteW;
    logic [1:0]       fwdA, fwdB;
    logic [4:0]       saE;
    mipsPkg::wordT    jumpTarget, branchTarget, pcD, instrD, rd1E, rd2E, immE;
    mipsPkg::wordT    branchTargetE, pcE, pcM, aluOutM, storeDataM, resultM, resultW;
    mipsPkg::regAddrT rsD, rtD, rsE, rtE, dstE, dstEh, dstM, dstW;
    mipsPkg::aluOpT   aluOpE;
    mipsPkg::lsTypeT  lsTypeE, lsTypeEh, lsTypeM;

    assign debugWbRfWen_o = {4{rfWe}};

    fetchStage u_fetch (
        .clk(clk), .arstN_i(arstN_i), .stall_i(freeze | loadUseStall), .flushD_i(flushD),
        .jumpD_i(jumpD), .jumpTarget_i(jumpTarget),
        .branchTaken_i(branchTaken), .branchTarget_i(branchTarget),
        .instr_i(instr_i), .instAddr_o(instAddr_o), .instEn_o(instEn_o),
        .pcD_o(pcD), .instrD_o(instrD)
    );

    decodeStage u_decode (
        .clk(clk), .arstN_i(arstN_i), .stall_i(freeze), .bubble_i(loadUseStall),
        .pcD_i(pcD), .instrD_i(instrD),
        .weM_i(rfWe), .waM_i(debugWbRfWnum_o), .wdM_i(debugWbRfWdata_o),
        .jumpD_o(jumpD), .jumpTarget_o(jumpTarget), .rsD_o(rsD), .rtD_o(rtD),
        .rsE_o(rsE), .rtE_o(rtE), .rd1E_o(rd1E), .rd2E_o(rd2E), .immE_o(immE), .saE_o(saE),
        .aluOpE_o(aluOpE), .aluImmE_o(aluImmE), .lsTypeE_o(lsTypeE),
        .regWriteE_o(regWriteE), .dstE_o(dstE), .isBranchE_o(isBranchE),
        .branchNeE_o(branchNeE), .branchTargetE_o(branchTargetE), .pcE_o(pcE)
    );

    executeStage u_execute (
        .clk(clk), .arstN_i(arstN_i), .stall_i(freeze),
        .rd1E_i(rd1E), .rd2E_i(rd2E), .immE_i(immE), .saE_i(saE),
        .aluOpE_i(aluOpE), .aluImmE_i(aluImmE), .lsTypeE_i(lsTypeE),
        .regWriteE_i(regWriteE), .dstE_i(dstE), .isBranchE_i(isBranchE),
        .branchNeE_i(branchNeE), .branchTargetE_i(branchTargetE), .pcE_i(pcE),
        .fwdA_i(fwdA), .fwdB_i(fwdB), .resultM_i(resultM), .resultW_i(resultW),
        .branchTaken_o(branchTaken), .branchTarget_o(branchTarget),
        .pcM_o(pcM), .aluOutM_o(aluOutM), .storeDataM_o(storeDataM),
        .lsTypeM_o(lsTypeM), .regWriteM_o(regWriteM), .dstM_o(dstM),
        .lsTypeE_o(lsTypeEh), .dstE_o(dstEh)
    );

    memAccess u_mem (
        .clk(clk), .arstN_i(arstN_i), .stall_i(freeze),
        .pcM_i(pcM), .aluOutM_i(aluOutM), .storeDataM_i(storeDataM),
        .lsTypeM_i(lsTypeM), .regWriteM_i(regWriteM), .dstM_i(dstM), .memRdata_i(memRdata_i),
        .memEn_o(memEn_o), .memAddr_o(memAddr_o), .memWen_o(memWen_o), .memWdata_o(memWdata_o),
        .resultM_o(resultM), .resultFinal_o(debugWbRfWdata_o),
        .rfWe_o(rfWe), .rfWa_o(debugWbRfWnum_o),
        .resultW_o(resultW), .dstW_o(dstW), .regWriteW_o(regWriteW), .debugPc_o(debugWbPc_o)
    );

    hazardUnit u_hazard (
        .iStall_i(iStall_i), .dStall_i(dStall_i),
        .rsD_i(rsD), .rtD_i(rtD), .rsE_i(rsE), .rtE_i(rtE),
        .lsTypeE_i(lsTypeEh), .dstE_i(dstEh), .regWriteE_i(regWriteE),
        .lsTypeM_i(lsTypeM), .dstM_i(dstM), .regWriteM_i(regWriteM),
        .dstW_i(dstW), .regWriteW_i(regWriteW), .branchTaken_i(branchTaken),
        .freeze_o(freeze), .loadUseStall_o(loadUseStall), .flushD_o(flushD),
        .fwdA_o(fwdA), .fwdB_o(fwdB), .longestStall_o(longestStall_o)
    );

endmodule

// File: hazardUnit.sv
module hazardUnit (
    input  logic             iStall_i,
    input  logic             dStall_i,
    input  mipsPkg::regAddrT rsD_i,
    input  mipsPkg::regAddrT rtD_i,
    input  mipsPkg::regAddrT rsE_i,
    input  mipsPkg::regAddrT rtE_i,
    input  mipsPkg::lsTypeT  lsTypeE_i,
    input  mipsPkg::regAddrT dstE_i,
    input  logic             regWriteE_i,
    input  mipsPkg::lsTypeT  lsTypeM_i,
    input  mipsPkg::regAddrT dstM_i,
    input  logic             regWriteM_i,
    input  mipsPkg::regAddrT dstW_i,
    input  logic             regWriteW_i,
    input  logic             branchTaken_i,
    output logic             freeze_o,
    output logic             loadUseStall_o,
    output logic             flushD_o,
    output logic [1:0]       fwdA_o,
    output logic [1:0]       fwdB_o,
    output logic             longestStall_o
);

    function automatic logic [1:0] fwdSel(mipsPkg::regAddrT src);
        if (src == '0)
            return 2'd0;
        if (regWriteM_i && dstM_i == src)
            return 2'd1;    // newest value wins
        if (regWriteW_i && dstW_i == src)
            return 2'd2;
        return 2'd0;
    endfunction

    function automatic logic loadHits(mipsPkg::lsTypeT ls, logic we, mipsPkg::regAddrT dst);
        return (ls == mipsPkg::lsLb || ls == mipsPkg::lsLw) && we && dst != '0 &&
               (dst == rsD_i || dst == rtD_i);
    endfunction

    always_comb begin
        fwdA_o = fwdSel(rsE_i);
        fwdB_o = fwdSel(rtE_i);
        // with a taken branch leaving execute, a load in memory reaches
        // write-back in time for the delay slot to forward from it
        loadUseStall_o = (loadHits(lsTypeE_i, regWriteE_i, dstE_i) ||
                          loadHits(lsTypeM_i, regWriteM_i, dstM_i)) && !branchTaken_i;
    end

    assign freeze_o       = iStall_i | dStall_i;
    assign longestStall_o = iStall_i | dStall_i;
    assign flushD_o       = branchTaken_i;

endmodule

// File: memAccess.sv
module memAccess (
    input  logic             clk,
    input  logic             arstN_i,
    input  logic             stall_i,
    input  mipsPkg::wordT    pcM_i,
    input  mipsPkg::wordT    aluOutM_i,
    input  mipsPkg::wordT    storeDataM_i,
    input  mipsPkg::lsTypeT  lsTypeM_i,
    input  logic             regWriteM_i,
    input  mipsPkg::regAddrT dstM_i,
    input  mipsPkg::wordT    memRdata_i,
    output logic             memEn_o,
    output mipsPkg::wordT    memAddr_o,
    output logic [3:0]       memWen_o,
    output mipsPkg::wordT    memWdata_o,
    output mipsPkg::wordT    resultM_o,
    output mipsPkg::wordT    resultFinal_o,
    output logic             rfWe_o,
    output mipsPkg::regAddrT rfWa_o,
    output mipsPkg::wordT    resultW_o,
    output mipsPkg::regAddrT dstW_o,
    output logic             regWriteW_o,
    output mipsPkg::wordT    debugPc_o
);

    logic       isLoad, isStore;
    logic [1:0] lane;
    logic [7:0] loadByte;

    assign lane     = aluOutM_i[1:0];
    assign isLoad   = lsTypeM_i == mipsPkg::lsLb || lsTypeM_i == mipsPkg::lsLw;
    assign isStore  = lsTypeM_i == mipsPkg::lsSb || lsTypeM_i == mipsPkg::lsSw;
    assign loadByte = memRdata_i[8*lane +: 8];

    assign memEn_o    = isLoad | isStore;
    assign memAddr_o  = aluOutM_i;
    assign memWdata_o = (lsTypeM_i == mipsPkg::lsSb) ? {4{storeDataM_i[7:0]}} : storeDataM_i;
    assign memWen_o   = (lsTypeM_i == mipsPkg::lsSw) ? 4'hf :
                        (lsTypeM_i == mipsPkg::lsSb) ? 4'b0001 << lane : 4'h0;

    assign resultM_o     = aluOutM_i;     // load data too late for forwarding
    assign resultFinal_o = !isLoad                     ? aluOutM_i :
                           (lsTypeM_i == mipsPkg::lsLb) ? {{24{loadByte[7]}}, loadByte} :
                                                          memRdata_i;
    assign rfWe_o    = regWriteM_i & ~stall_i;
    assign rfWa_o    = dstM_i;
    assign debugPc_o = pcM_i;

    // MEM/WB, feeds forwarding only
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i)
            regWriteW_o <= 1'b0;
        else if (!stall_i)
            regWriteW_o <= regWriteM_i;
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            resultW_o <= resultFinal_o;
            dstW_o    <= dstM_i;
        end
    end

    wordAligned: assert property (@(posedge clk) disable iff (!arstN_i)
        (lsTypeM_i == mipsPkg::lsLw || lsTypeM_i == mipsPkg::lsSw) |-> lane == 2'b00);

endmodule

// File: executeStage.sv
module executeStage (
    input  logic             clk,
    input  logic             arstN_i,
    input  logic             stall_i,
    input  mipsPkg::wordT    rd1E_i,
    input  mipsPkg::wordT    rd2E_i,
    input  mipsPkg::wordT    immE_i,
    input  logic [4:0]       saE_i,
    input  mipsPkg::aluOpT   aluOpE_i,
    input  logic             aluImmE_i,
    input  mipsPkg::lsTypeT  lsTypeE_i,
    input  logic             regWriteE_i,
    input  mipsPkg::regAddrT dstE_i,
    input  logic             isBranchE_i,
    input  logic             branchNeE_i,
    input  mipsPkg::wordT    branchTargetE_i,
    input  mipsPkg::wordT    pcE_i,
    input  logic [1:0]       fwdA_i,
    input  logic [1:0]       fwdB_i,
    input  mipsPkg::wordT    resultM_i,
    input  mipsPkg::wordT    resultW_i,
    output logic             branchTaken_o,
    output mipsPkg::wordT    branchTarget_o,
    output mipsPkg::wordT    pcM_o,
    output mipsPkg::wordT    aluOutM_o,
    output mipsPkg::wordT    storeDataM_o,
    output mipsPkg::lsTypeT  lsTypeM_o,
    output logic             regWriteM_o,
    output mipsPkg::regAddrT dstM_o,
    output mipsPkg::lsTypeT  lsTypeE_o,
    output mipsPkg::regAddrT dstE_o
);

    mipsPkg::wordT srcA, rtVal, srcB, aluOut;

    // 1 = memory stage, 2 = write-back
    assign srcA  = (fwdA_i == 2'd1) ? resultM_i :
                   (fwdA_i == 2'd2) ? resultW_i : rd1E_i;
    assign rtVal = (fwdB_i == 2'd1) ? resultM_i :
                   (fwdB_i == 2'd2) ? resultW_i : rd2E_i;
    assign srcB  = aluImmE_i ? immE_i : rtVal;

    always_comb begin
        case (aluOpE_i)
            mipsPkg::aluSub: aluOut = srcA - srcB;
            mipsPkg::aluAnd: aluOut = srcA & srcB;
            mipsPkg::aluOr:  aluOut = srcA | srcB;
            mipsPkg::aluXor: aluOut = srcA ^ srcB;
            mipsPkg::aluSlt: aluOut = {31'b0, $signed(srcA) < $signed(srcB)};
            mipsPkg::aluSll: aluOut = srcB << saE_i;
            mipsPkg::aluLui: aluOut = {srcB[15:0], 16'b0};
            default:         aluOut = srcA + srcB;
        endcase
    end

    assign branchTaken_o  = isBranchE_i & ((srcA == rtVal) ^ branchNeE_i);
    assign branchTarget_o = branchTargetE_i;
    assign lsTypeE_o      = lsTypeE_i;
    assign dstE_o         = dstE_i;

    // EX/MEM
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            lsTypeM_o   <= mipsPkg::lsNone;
            regWriteM_o <= 1'b0;
        end else if (!stall_i) begin
            lsTypeM_o   <= lsTypeE_i;
            regWriteM_o <= regWriteE_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pcM_o        <= pcE_i;
            aluOutM_o    <= aluOut;
            storeDataM_o <= rtVal;     // forwarded rt for stores
            dstM_o       <= dstE_i;
        end
    end

endmodule

// File: decodeStage.sv
module decodeStage (
    input  logic                    clk,
    input  logic                    arstN_i,
    input  logic                    stall_i,
    input  logic                    bubble_i,
    input  mipsPkg::wordT           pcD_i,
    input  mipsPkg::wordT           instrD_i,
    input  logic                    weM_i,
    input  mipsPkg::regAddrT        waM_i,
    input  mipsPkg::wordT           wdM_i,
    output logic                    jumpD_o,
    output mipsPkg::wordT           jumpTarget_o,
    output mipsPkg::regAddrT        rsD_o,
    output mipsPkg::regAddrT        rtD_o,
    output mipsPkg::regAddrT        rsE_o,
    output mipsPkg::regAddrT        rtE_o,
    output mipsPkg::wordT           rd1E_o,
    output mipsPkg::wordT           rd2E_o,
    output mipsPkg::wordT           immE_o,
    output logic [4:0]              saE_o,
    output mipsPkg::aluOpT          aluOpE_o,
    output logic                    aluImmE_o,
    output mipsPkg::lsTypeT         lsTypeE_o,
    output logic                    regWriteE_o,
    output mipsPkg::regAddrT        dstE_o,
    output logic                    isBranchE_o,
    output logic                    branchNeE_o,
    output mipsPkg::wordT           branchTargetE_o,
    output mipsPkg::wordT           pcE_o
);

    logic [5:0]       op;
    logic [5:0]       funct;
    mipsPkg::regAddrT rs, rt, rd, dst;
    mipsPkg::wordT    rd1, rd2, imm, pcPlus4;
    mipsPkg::aluOpT   aluOp;
    mipsPkg::lsTypeT  lsType;
    logic             signExt, aluImm, regWrite, dstRt, isBranch, branchNe, isJal;
    logic             legal;     // opcode and funct are supported

    assign op    = instrD_i[31:26];
    assign rs    = instrD_i[25:21];
    assign rt    = instrD_i[20:16];
    assign rd    = instrD_i[15:11];
    assign funct = instrD_i[5:0];

    regFile u_regFile (
        .clk(clk),
        .we_i(weM_i), .wa_i(waM_i), .wd_i(wdM_i),
        .ra1_i(rs), .ra2_i(rt),
        .rd1_o(rd1), .rd2_o(rd2)
    );

    always_comb begin
        aluOp    = mipsPkg::aluAdd;
        lsType   = mipsPkg::lsNone;
        signExt  = 1'b1;
        aluImm   = 1'b1;
        regWrite = 1'b0;
        dstRt    = 1'b1;
        isBranch = 1'b0;
        branchNe = 1'b0;
        jumpD_o  = 1'b0;
        isJal    = 1'b0;
        legal    = 1'b1;
        case (op)
            mipsPkg::opSpecial: begin
                aluImm   = 1'b0;
                dstRt    = 1'b0;
                regWrite = instrD_i != '0;     // all-zero word is a nop
                case (funct)
                    mipsPkg::fnSll:  aluOp = mipsPkg::aluSll;
                    mipsPkg::fnAddu: aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   aluOp = mipsPkg::aluOr;
                    mipsPkg::fnXor:  aluOp = mipsPkg::aluXor;
                    mipsPkg::fnSlt:  aluOp = mipsPkg::aluSlt;
                    default: begin
                        regWrite = 1'b0;
                        legal    = 1'b0;
                    end
                endcase
            end
            mipsPkg::opJ: jumpD_o = 1'b1;
            mipsPkg::opJal: begin
                jumpD_o  = 1'b1;
                isJal    = 1'b1;
                regWrite = 1'b1;
            end
            mipsPkg::opBeq: isBranch = 1'b1;
            mipsPkg::opBne: begin
                isBranch = 1'b1;
                branchNe = 1'b1;
            end
            mipsPkg::opAddiu: regWrite = 1'b1;
            mipsPkg::opOri: begin
                aluOp    = mipsPkg::aluOr;
                signExt  = 1'b0;
                regWrite = 1'b1;
            end
            mipsPkg::opLui: begin
                aluOp    = mipsPkg::aluLui;
                signExt  = 1'b0;
                regWrite = 1'b1;
            end
            mipsPkg::opLb: begin
                lsType   = mipsPkg::lsLb;
                regWrite = 1'b1;
            end
            mipsPkg::opLw: begin
                lsType   = mipsPkg::lsLw;
                regWrite = 1'b1;
            end
            mipsPkg::opSb: lsType = mipsPkg::lsSb;
            mipsPkg::opSw: lsType = mipsPkg::lsSw;
            default: legal = 1'b0;
        endcase
    end

    assign imm          = signExt ? {{16{instrD_i[15]}}, instrD_i[15:0]} : {16'b0, instrD_i[15:0]};
    assign pcPlus4      = pcD_i + 32'd4;
    assign jumpTarget_o = {pcPlus4[31:28], instrD_i[25:0], 2'b00};
    assign dst          = isJal ? mipsPkg::regRa : dstRt ? rt : rd;
    assign rsD_o        = rs;
    assign rtD_o        = rt;

    // ID/EX control
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            regWriteE_o <= 1'b0;
            lsTypeE_o   <= mipsPkg::lsNone;
            isBranchE_o <= 1'b0;
        end else if (!stall_i) begin
            regWriteE_o <= regWrite & ~bubble_i;
            lsTypeE_o   <= bubble_i ? mipsPkg::lsNone : lsType;
            isBranchE_o <= isBranch & ~bubble_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            rsE_o           <= isJal ? '0 : rs;   // jal adds pc+8 and zero, nothing to forward
            rtE_o           <= rt;
            rd1E_o          <= isJal ? pcD_i + 32'd8 : rd1;
            rd2E_o          <= rd2;
            immE_o          <= isJal ? '0 : imm;
            saE_o           <= instrD_i[10:6];
            aluOpE_o        <= aluOp;
            aluImmE_o       <= aluImm;
            dstE_o          <= dst;
            branchNeE_o     <= branchNe;
            branchTargetE_o <= pcPlus4 + {imm[29:0], 2'b00};
            pcE_o           <= pcD_i;
        end
    end

    // only kept instructions may reach decode
    decodeLegal: assert property (@(posedge clk) disable iff (!arstN_i)
        legal);

endmodule

// File: regFile.sv
module regFile (
    input  logic             clk,
    input  logic             we_i,
    input  mipsPkg::regAddrT wa_i,
    input  mipsPkg::wordT    wd_i,
    input  mipsPkg::regAddrT ra1_i,
    input  mipsPkg::regAddrT ra2_i,
    output mipsPkg::wordT    rd1_o,
    output mipsPkg::wordT    rd2_o
);

    mipsPkg::wordT regs [32];

    always_ff @(posedge clk) begin
        if (we_i && wa_i != '0)
            regs[wa_i] <= wd_i;
    end

    // same-cycle write shows up on the read ports
    assign rd1_o = (ra1_i == '0)               ? '0   :
                   (we_i && wa_i == ra1_i)     ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0)               ? '0   :
                   (we_i && wa_i == ra2_i)     ? wd_i : regs[ra2_i];

endmodule

// File: fetchStage.sv
module fetchStage (
    input  logic          clk,
    input  logic          arstN_i,
    input  logic          stall_i,
    input  logic          flushD_i,
    input  logic          jumpD_i,
    input  mipsPkg::wordT jumpTarget_i,
    input  logic          branchTaken_i,
    input  mipsPkg::wordT branchTarget_i,
    input  mipsPkg::wordT instr_i,
    output mipsPkg::wordT instAddr_o,
    output logic          instEn_o,
    output mipsPkg::wordT pcD_o,
    output mipsPkg::wordT instrD_o
);

    mipsPkg::wordT pc;
    mipsPkg::wordT pcNext;
    logic          fetchOn;     // first cycle after reset release

    // branch correction beats a jump in decode
    assign pcNext = branchTaken_i ? branchTarget_i :
                    jumpD_i       ? jumpTarget_i   : pc + 32'd4;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            pc      <= mipsPkg::pcReset;
            fetchOn <= 1'b0;
        end else begin
            fetchOn <= 1'b1;
            if (fetchOn && !stall_i)
                pc <= pcNext;
        end
    end

    // IF/ID, zero word is a no-op
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i)
            instrD_o <= '0;
        else if (!stall_i)
            instrD_o <= (flushD_i || !fetchOn) ? '0 : instr_i;
    end

    always_ff @(posedge clk) begin
        if (!stall_i)
            pcD_o <= pc;
    end

    assign instAddr_o = pc;
    assign instEn_o   = fetchOn;

    pcAligned: assert property (@(posedge clk) disable iff (!arstN_i)
        pc[1:0] == 2'b00);

endmodule

// File: mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluLui
    } aluOpT;

    typedef enum logic [2:0] {
        lsNone,
        lsLb,
        lsLw,
        lsSb,
        lsSw
    } lsTypeT;

    localparam wordT    pcReset = 32'hbfc0_0000;
    localparam regAddrT regRa   = 5'd31;    // link register

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLb      = 6'h20;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSb      = 6'h28;
    localparam logic [5:0] opSw      = 6'h2b;

    // funct field of SPECIAL
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;

endpackage
